// ==== compile.f ====
+incdir+hw
hw/io_pkg.sv
hw/io_gpio.sv
hw/io_scratch.sv
hw/io_timer.sv
hw/io_read_mux.sv
hw/io_subsystem.sv
tb/tb_io_subsystem.sv

// ==== hw/io_consts.svh ====
// i/o map and register offsets for the peripheral bus, included by every block that decodes
`ifndef IO_CONSTS_SVH
`define IO_CONSTS_SVH

// ------------------------------
// gpio ports
// ------------------------------
// one byte each, low address byte only
`define IO_GPIO0_ADDR		8'h01
`define IO_GPIO1_ADDR		8'h02

// ------------------------------
// scratch register file
// ------------------------------
// base must be aligned to depth
`define IO_SCRATCH_BASE		8'h20
`define IO_SCRATCH_DEPTH	8

// ------------------------------
// interval timer
// ------------------------------
`define IO_TIMER_BASE		8'h10
// offsets inside the four-byte timer block
`define IO_TIMER_RELOAD_LO	2'd0
`define IO_TIMER_RELOAD_HI	2'd1
`define IO_TIMER_CTRL		2'd2
`define IO_TIMER_STATUS		2'd3

// read value when no peripheral claims the address
`define IO_UNMAPPED_DATA	8'hff

`endif

// ==== hw/io_gpio.sv ====
// one-byte gpio port: output latch written and input port read at a single i/o address
`timescale 1ns/1ps
`include "io_consts.svh"

module io_gpio #(
	parameter io_pkg::bus_data_t io_address = `IO_GPIO0_ADDR
) (
	input  logic              clk,
	input  logic              n_reset,
	// peripheral bus
	input  io_pkg::bus_addr_t bus_address,
	input  io_pkg::bus_data_t bus_write_data,
	input  logic              bus_io_read,
	input  logic              bus_io_write,
	output logic              read_ready,
	output io_pkg::bus_data_t read_data,
	// port pins
	output io_pkg::bus_data_t gpo,
	input  io_pkg::bus_data_t gpi
);

	logic              ff_io_read;
	logic              ff_io_write;
	logic              w_read_edge;
	logic              w_write_edge;
	logic              w_dec;
	io_pkg::bus_data_t ff_gpo;
	logic              ff_read_ready;
	io_pkg::bus_data_t ff_read_data;

	// ------------------------------
	// strobe edge detect
	// ------------------------------
	// previous strobe levels, an access fires only on low-to-high
	always_ff @(posedge clk) begin
		if (!n_reset) begin
			ff_io_read  <= 1'b0;
			ff_io_write <= 1'b0;
		end else begin
			ff_io_read  <= bus_io_read;
			ff_io_write <= bus_io_write;
		end
	end

	assign w_read_edge  = bus_io_read & ~ff_io_read;
	assign w_write_edge = bus_io_write & ~ff_io_write;

	// upper address byte is ignored
	assign w_dec = (bus_address[7:0] == io_address);

	// ------------------------------
	// output latch
	// ------------------------------
	always_ff @(posedge clk) begin
		if (!n_reset) begin
			ff_gpo <= '0;
		end else if (w_write_edge && w_dec) begin
			ff_gpo <= bus_write_data;
		end
	end

	assign gpo = ff_gpo;

	// ------------------------------
	// read response
	// ------------------------------
	// ready for one cycle, data zero when idle so the merger can or it
	always_ff @(posedge clk) begin
		if (!n_reset) begin
			ff_read_ready <= 1'b0;
			ff_read_data  <= '0;
		end else if (w_read_edge && w_dec) begin
			ff_read_ready <= 1'b1;
			ff_read_data  <= gpi;
		end else begin
			ff_read_ready <= 1'b0;
			ff_read_data  <= '0;
		end
	end

	assign read_ready = ff_read_ready;
	assign read_data  = ff_read_data;

endmodule

// ==== hw/io_pkg.sv ====
// shared bus and timer types for the i/o subsystem, referenced by scoped name from each block
package io_pkg;

	// ------------------------------
	// bus types
	// ------------------------------

	// full 16-bit bus address
	// peripherals only look at the low byte
	typedef logic [15:0] bus_addr_t;

	// one data byte on the 8-bit data path
	// used for both write data and read return
	typedef logic [7:0] bus_data_t;

	// ------------------------------
	// timer types
	// ------------------------------

	// reload value and running count share one width
	// built from the reload low and high bytes
	typedef logic [15:0] timer_count_t;

	// control register bit positions
	// enable starts the count and loads it from reload
	localparam int TIMER_CTRL_ENABLE = 0;
	// irq enable gates the sticky expiry flag onto timer_irq
	localparam int TIMER_CTRL_IRQ_EN = 1;

	// the remaining control bits are plain storage
	// they read back as written and have no effect

endpackage

// ==== hw/io_read_mux.sv ====
// read-return merger: ors the peripheral responses and answers unclaimed reads with all ones
`timescale 1ns/1ps
`include "io_consts.svh"

module io_read_mux (
	input  logic              clk,
	input  logic              n_reset,
	input  logic              bus_io_read,
	// per-peripheral responses, data zero when not ready
	input  logic              gpio0_read_ready,
	input  io_pkg::bus_data_t gpio0_read_data,
	input  logic              gpio1_read_ready,
	input  io_pkg::bus_data_t gpio1_read_data,
	input  logic              scratch_read_ready,
	input  io_pkg::bus_data_t scratch_read_data,
	input  logic              timer_read_ready,
	input  io_pkg::bus_data_t timer_read_data,
	// merged return to the bus master
	output logic              bus_read_ready,
	output io_pkg::bus_data_t bus_read_data
);

	logic              ff_io_read;
	logic              ff_read_pending;
	logic              w_any_ready;
	io_pkg::bus_data_t w_merged_data;

	// own copy of the read edge, lines up with the responders' ready cycle
	always_ff @(posedge clk) begin
		if (!n_reset) begin
			ff_io_read      <= 1'b0;
			ff_read_pending <= 1'b0;
		end else begin
			ff_io_read      <= bus_io_read;
			ff_read_pending <= bus_io_read & ~ff_io_read;
		end
	end

	assign w_any_ready   = gpio0_read_ready | gpio1_read_ready
		| scratch_read_ready | timer_read_ready;
	assign w_merged_data = gpio0_read_data | gpio1_read_data
		| scratch_read_data | timer_read_data;

	// nobody answered a pending read, so it is unmapped
	assign bus_read_ready = w_any_ready | ff_read_pending;
	assign bus_read_data  = w_any_ready ? w_merged_data
		: (ff_read_pending ? `IO_UNMAPPED_DATA : '0);

	// overlapping decodes would corrupt the or-merge
	a_one_responder: assert property (@(posedge clk) disable iff (!n_reset)
		$onehot0({gpio0_read_ready, gpio1_read_ready, scratch_read_ready, timer_read_ready}))
		else $error("more than one peripheral answered the same read");

	// a responder may only answer in the cycle after a read edge
	a_ready_in_slot: assert property (@(posedge clk) disable iff (!n_reset)
		w_any_ready |-> ff_read_pending)
		else $error("peripheral ready outside the read response slot");

endmodule

// ==== hw/io_scratch.sv ====
// scratch register file: depth bytes of read/write storage over an aligned i/o address block
`timescale 1ns/1ps
`include "io_consts.svh"

module io_scratch #(
	parameter io_pkg::bus_data_t base_address = `IO_SCRATCH_BASE,
	parameter int                depth        = `IO_SCRATCH_DEPTH
) (
	input  logic              clk,
	input  logic              n_reset,
	input  io_pkg::bus_addr_t bus_address,
	input  io_pkg::bus_data_t bus_write_data,
	input  logic              bus_io_read,
	input  logic              bus_io_write,
	output logic              read_ready,
	output io_pkg::bus_data_t read_data
);

	localparam int                index_bits = $clog2(depth);
	// clears the byte index bits out of the low address byte
	localparam io_pkg::bus_data_t block_mask = ~io_pkg::bus_data_t'(depth - 1);

	logic                  ff_io_read;
	logic                  ff_io_write;
	logic                  w_dec;
	logic [index_bits-1:0] w_index;
	io_pkg::bus_data_t     ff_mem [depth];
	logic                  ff_read_ready;
	io_pkg::bus_data_t     ff_read_data;

	always_ff @(posedge clk) begin
		if (!n_reset) begin
			ff_io_read  <= 1'b0;
			ff_io_write <= 1'b0;
		end else begin
			ff_io_read  <= bus_io_read;
			ff_io_write <= bus_io_write;
		end
	end

	// block hit and byte select
	assign w_dec   = ((bus_address[7:0] & block_mask) == base_address);
	assign w_index = bus_address[index_bits-1:0];

	// ------------------------------
	// storage and read return
	// ------------------------------
	// bytes come up zero after reset
	always_ff @(posedge clk) begin
		if (!n_reset) begin
			for (int i = 0; i < depth; i++) begin
				ff_mem[i] <= '0;
			end
			ff_read_ready <= 1'b0;
			ff_read_data  <= '0;
		end else begin
			if (bus_io_write && !ff_io_write && w_dec) begin
				ff_mem[w_index] <= bus_write_data;
			end
			// one-cycle ready, zero data otherwise
			ff_read_ready <= bus_io_read && !ff_io_read && w_dec;
			ff_read_data  <= (bus_io_read && !ff_io_read && w_dec) ? ff_mem[w_index] : '0;
		end
	end

	assign read_ready = ff_read_ready;
	assign read_data  = ff_read_data;

	// a misaligned base would alias bytes across the block boundary
	a_base_aligned: assert property (@(posedge clk) (int'(base_address) % depth) == 0)
		else $error("scratch base 0x%02h not aligned to depth %0d", base_address, depth);

endmodule

// ==== hw/io_subsystem.sv ====
// top of the i/o subsystem: fans the peripheral bus to each block and merges the read returns
`timescale 1ns/1ps
`include "io_consts.svh"

module io_subsystem (
	input  logic              clk,
	input  logic              n_reset,
	// peripheral bus
	input  io_pkg::bus_addr_t bus_address,
	input  io_pkg::bus_data_t bus_write_data,
	input  logic              bus_io_read,
	input  logic              bus_io_write,
	output logic              bus_read_ready,
	output io_pkg::bus_data_t bus_read_data,
	// gpio pins
	output io_pkg::bus_data_t gpo0,
	output io_pkg::bus_data_t gpo1,
	input  io_pkg::bus_data_t gpi0,
	input  io_pkg::bus_data_t gpi1,
	// interrupt level
	output logic              timer_irq
);

	// ------------------------------
	// per-peripheral read returns
	// ------------------------------
	logic              gpio0_read_ready;
	io_pkg::bus_data_t gpio0_read_data;
	logic              gpio1_read_ready;
	io_pkg::bus_data_t gpio1_read_data;
	logic              scratch_read_ready;
	io_pkg::bus_data_t scratch_read_data;
	logic              timer_read_ready;
	io_pkg::bus_data_t timer_read_data;

	// two gpio ports, same block at different addresses
	io_gpio #(.io_address(`IO_GPIO0_ADDR)) u_gpio0 (
		.clk            (clk),
		.n_reset        (n_reset),
		.bus_address    (bus_address),
		.bus_write_data (bus_write_data),
		.bus_io_read    (bus_io_read),
		.bus_io_write   (bus_io_write),
		.read_ready     (gpio0_read_ready),
		.read_data      (gpio0_read_data),
		.gpo            (gpo0),
		.gpi            (gpi0)
	);

	io_gpio #(.io_address(`IO_GPIO1_ADDR)) u_gpio1 (
		.clk            (clk),
		.n_reset        (n_reset),
		.bus_address    (bus_address),
		.bus_write_data (bus_write_data),
		.bus_io_read    (bus_io_read),
		.bus_io_write   (bus_io_write),
		.read_ready     (gpio1_read_ready),
		.read_data      (gpio1_read_data),
		.gpo            (gpo1),
		.gpi            (gpi1)
	);

	io_scratch #(
		.base_address (`IO_SCRATCH_BASE),
		.depth        (`IO_SCRATCH_DEPTH)
	) u_scratch (
		.clk            (clk),
		.n_reset        (n_reset),
		.bus_address    (bus_address),
		.bus_write_data (bus_write_data),
		.bus_io_read    (bus_io_read),
		.bus_io_write   (bus_io_write),
		.read_ready     (scratch_read_ready),
		.read_data      (scratch_read_data)
	);

	io_timer #(.base_address(`IO_TIMER_BASE)) u_timer (
		.clk            (clk),
		.n_reset        (n_reset),
		.bus_address    (bus_address),
		.bus_write_data (bus_write_data),
		.bus_io_read    (bus_io_read),
		.bus_io_write   (bus_io_write),
		.read_ready     (timer_read_ready),
		.read_data      (timer_read_data),
		.timer_irq      (timer_irq)
	);

	// merger also answers unmapped reads
	io_read_mux u_read_mux (
		.clk                (clk),
		.n_reset            (n_reset),
		.bus_io_read        (bus_io_read),
		.gpio0_read_ready   (gpio0_read_ready),
		.gpio0_read_data    (gpio0_read_data),
		.gpio1_read_ready   (gpio1_read_ready),
		.gpio1_read_data    (gpio1_read_data),
		.scratch_read_ready (scratch_read_ready),
		.scratch_read_data  (scratch_read_data),
		.timer_read_ready   (timer_read_ready),
		.timer_read_data    (timer_read_data),
		.bus_read_ready     (bus_read_ready),
		.bus_read_data      (bus_read_data)
	);

endmodule

// ==== hw/io_timer.sv ====
// 16-bit interval timer with reload, sticky expiry flag and level interrupt for the i/o top level
`timescale 1ns/1ps
`include "io_consts.svh"

module io_timer #(
	parameter io_pkg::bus_data_t base_address = `IO_TIMER_BASE
) (
	input  logic              clk,
	input  logic              n_reset,
	input  io_pkg::bus_addr_t bus_address,
	input  io_pkg::bus_data_t bus_write_data,
	input  logic              bus_io_read,
	input  logic              bus_io_write,
	output logic              read_ready,
	output io_pkg::bus_data_t read_data,
	output logic              timer_irq
);

	logic                 ff_io_read;
	logic                 ff_io_write;
	logic                 w_read_edge;
	logic                 w_write_edge;
	logic                 w_dec;
	logic [1:0]           w_offset;
	logic                 w_ctrl_write;
	logic                 w_status_read;
	io_pkg::bus_data_t    ff_reload_lo;
	io_pkg::bus_data_t    ff_reload_hi;
	io_pkg::bus_data_t    ff_ctrl;
	io_pkg::timer_count_t w_reload;
	io_pkg::timer_count_t ff_count;
	logic                 w_running;
	logic                 w_expire;
	logic                 ff_flag;
	logic                 ff_read_ready;
	io_pkg::bus_data_t    ff_read_data;

	// ------------------------------
	// bus decode
	// ------------------------------
	always_ff @(posedge clk) begin
		if (!n_reset) begin
			ff_io_read  <= 1'b0;
			ff_io_write <= 1'b0;
		end else begin
			ff_io_read  <= bus_io_read;
			ff_io_write <= bus_io_write;
		end
	end

	assign w_read_edge  = bus_io_read & ~ff_io_read;
	assign w_write_edge = bus_io_write & ~ff_io_write;

	// four registers in a 4-byte aligned block
	assign w_dec    = (bus_address[7:2] == base_address[7:2]);
	assign w_offset = bus_address[1:0];

	assign w_ctrl_write  = w_write_edge && w_dec && (w_offset == `IO_TIMER_CTRL);
	assign w_status_read = w_read_edge && w_dec && (w_offset == `IO_TIMER_STATUS);

	// ------------------------------
	// registers
	// ------------------------------
	// writes to the read-only status offset are dropped
	always_ff @(posedge clk) begin
		if (!n_reset) begin
			ff_reload_lo <= '0;
			ff_reload_hi <= '0;
			ff_ctrl      <= '0;
		end else if (w_write_edge && w_dec) begin
			case (w_offset)
				`IO_TIMER_RELOAD_LO: ff_reload_lo <= bus_write_data;
				`IO_TIMER_RELOAD_HI: ff_reload_hi <= bus_write_data;
				`IO_TIMER_CTRL:      ff_ctrl      <= bus_write_data;
				default:             ;
			endcase
		end
	end

	assign w_reload = {ff_reload_hi, ff_reload_lo};

	// ------------------------------
	// counter and expiry
	// ------------------------------
	// a zero reload holds the timer stopped
	assign w_running = ff_ctrl[io_pkg::TIMER_CTRL_ENABLE] && (w_reload != '0);
	// counts reload down to 0 so the period is reload+1 cycles
	assign w_expire  = w_running && (ff_count == '0);

	always_ff @(posedge clk) begin
		if (!n_reset) begin
			ff_count <= '0;
		end else if (w_ctrl_write && bus_write_data[io_pkg::TIMER_CTRL_ENABLE]) begin
			ff_count <= w_reload;
		end else if (w_expire) begin
			ff_count <= w_reload;
		end else if (w_running) begin
			ff_count <= ff_count - io_pkg::timer_count_t'(1);
		end
	end

	// a fresh expiry wins over the read-clear of the sticky flag
	always_ff @(posedge clk) begin
		if (!n_reset) begin
			ff_flag <= 1'b0;
		end else if (w_expire) begin
			ff_flag <= 1'b1;
		end else if (w_status_read) begin
			ff_flag <= 1'b0;
		end
	end

	assign timer_irq = ff_flag & ff_ctrl[io_pkg::TIMER_CTRL_IRQ_EN];

	// ------------------------------
	// read response
	// ------------------------------
	always_ff @(posedge clk) begin
		if (!n_reset) begin
			ff_read_ready <= 1'b0;
			ff_read_data  <= '0;
		end else begin
			ff_read_ready <= w_read_edge && w_dec;
			ff_read_data  <= '0;
			if (w_read_edge && w_dec) begin
				case (w_offset)
					`IO_TIMER_RELOAD_LO: ff_read_data <= ff_reload_lo;
					`IO_TIMER_RELOAD_HI: ff_read_data <= ff_reload_hi;
					`IO_TIMER_CTRL:      ff_read_data <= ff_ctrl;
					default:             ff_read_data <= {7'd0, ff_flag};
				endcase
			end
		end
	end

	assign read_ready = ff_read_ready;
	assign read_data  = ff_read_data;

	// a running timer reloads a nonzero count and never expires two cycles in a row
	a_no_double_expire: assert property (@(posedge clk) disable iff (!n_reset)
		w_expire |=> !w_expire)
		else $error("timer expired in two consecutive cycles");

endmodule

// ==== run.sh ====
#!/bin/sh
# build the io subsystem testbench with verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_io_subsystem -f compile.f \
	|| { echo "verilator build failed"; exit 1; }

out="$(./obj_dir/Vtb_io_subsystem)"
echo "$out"
echo "$out" | grep -qx "TEST PASS" && exit 0 || exit 1

// ==== tb/tb_io_subsystem.sv ====
// testbench for the i/o subsystem that applies a table of bus accesses and checks reads, pins and irq
`timescale 1ns/1ps

module tb_io_subsystem;

	// entry kinds for bus accesses, idle time, gpi drive and pin checks
	typedef enum logic [2:0] {
		K_WRITE, K_READ, K_WAIT, K_GPI, K_GPO0, K_GPO1, K_IRQ
	} kind_t;

	typedef struct packed {
		kind_t             kind;
		io_pkg::bus_addr_t addr;
		io_pkg::bus_data_t wdata;
		io_pkg::bus_data_t exp;
		io_pkg::bus_data_t mask;
	} entry_t;

	logic              clk;
	logic              n_reset;
	io_pkg::bus_addr_t bus_address;
	io_pkg::bus_data_t bus_write_data;
	logic              bus_io_read;
	logic              bus_io_write;
	logic              bus_read_ready;
	io_pkg::bus_data_t bus_read_data;
	io_pkg::bus_data_t gpo0;
	io_pkg::bus_data_t gpo1;
	io_pkg::bus_data_t gpi0;
	io_pkg::bus_data_t gpi1;
	logic              timer_irq;

	entry_t            table_q[$];
	integer            seed;
	integer            rnd;
	io_pkg::bus_data_t gpi_val [4];
	int                error_count = 0;
	int                pass_count = 0;
	int                fail_count = 0;
	int                watchdog_cycles = 0;

	io_subsystem u_io_subsystem (
		.clk            (clk),
		.n_reset        (n_reset),
		.bus_address    (bus_address),
		.bus_write_data (bus_write_data),
		.bus_io_read    (bus_io_read),
		.bus_io_write   (bus_io_write),
		.bus_read_ready (bus_read_ready),
		.bus_read_data  (bus_read_data),
		.gpo0           (gpo0),
		.gpo1           (gpo1),
		.gpi0           (gpi0),
		.gpi1           (gpi1),
		.timer_irq      (timer_irq)
	);

	// 4 ns period
	initial clk = 1'b0;
	always #2 clk = ~clk;

	// ------------------------------
	// table building
	// ------------------------------
	task automatic push_entry(input kind_t kind, input io_pkg::bus_addr_t addr,
		input io_pkg::bus_data_t wdata, input io_pkg::bus_data_t exp,
		input io_pkg::bus_data_t mask);
		entry_t ent;
		ent.kind  = kind;
		ent.addr  = addr;
		ent.wdata = wdata;
		ent.exp   = exp;
		ent.mask  = mask;
		table_q.push_back(ent);
	endtask

	task automatic write_at(input io_pkg::bus_addr_t addr, input io_pkg::bus_data_t data);
		push_entry(K_WRITE, addr, data, 8'h00, 8'h00);
	endtask

	task automatic read_expect(input io_pkg::bus_addr_t addr, input io_pkg::bus_data_t exp);
		push_entry(K_READ, addr, 8'h00, exp, 8'hff);
	endtask

	task automatic idle_for(input io_pkg::bus_data_t cycles);
		push_entry(K_WAIT, 16'h0000, cycles, 8'h00, 8'h00);
	endtask

	task automatic set_gpi(input int port, input io_pkg::bus_data_t value);
		push_entry(K_GPI, io_pkg::bus_addr_t'(port), value, 8'h00, 8'h00);
	endtask

	task automatic pin_expect(input kind_t kind, input io_pkg::bus_data_t exp);
		push_entry(kind, 16'h0000, 8'h00, exp, 8'hff);
	endtask

	// scratch contents depend on every byte of the address
	function automatic io_pkg::bus_data_t scratch_fill(input io_pkg::bus_addr_t addr);
		return addr[7:0] ^ addr[15:8] ^ 8'h5a;
	endfunction

	task automatic build_table();
		io_pkg::bus_addr_t addr;
		// pins straight out of reset
		pin_expect(K_GPO0, 8'h00);
		pin_expect(K_GPO1, 8'h00);
		pin_expect(K_IRQ, 8'h00);
		// each gpio write moves its own port only
		write_at(16'h0001, 8'ha5);
		pin_expect(K_GPO0, 8'ha5);
		pin_expect(K_GPO1, 8'h00);
		write_at(16'h0002, 8'h3c);
		pin_expect(K_GPO0, 8'ha5);
		pin_expect(K_GPO1, 8'h3c);
		// gpi reads before and after the pins change
		read_expect(16'h0001, gpi_val[0]);
		read_expect(16'h0002, gpi_val[1]);
		set_gpi(0, gpi_val[2]);
		set_gpi(1, gpi_val[3]);
		read_expect(16'h0002, gpi_val[3]);
		read_expect(16'h0001, gpi_val[2]);
		// fill all eight scratch bytes
		for (int i = 0; i < 8; i++) begin
			addr = io_pkg::bus_addr_t'(16'h0020 + i);
			write_at(addr, scratch_fill(addr));
		end
		// read back in a scrambled order 5 0 3 6 1 4 7 2
		for (int i = 0; i < 8; i++) begin
			addr = io_pkg::bus_addr_t'(16'h0020 + ((i * 3 + 5) % 8));
			read_expect(addr, scratch_fill(addr));
		end
		// unmapped reads get all ones and unmapped writes land nowhere
		read_expect(16'h0040, 8'hff);
		read_expect(16'h0028, 8'hff);
		write_at(16'h0040, 8'h5a);
		write_at(16'h0028, 8'h5a);
		pin_expect(K_GPO0, 8'ha5);
		pin_expect(K_GPO1, 8'h3c);
		read_expect(16'h0020, scratch_fill(16'h0020));
		read_expect(16'h0027, scratch_fill(16'h0027));
		// timer reload 20 gives a 21-cycle period
		write_at(16'h0010, 8'd20);
		write_at(16'h0011, 8'h00);
		write_at(16'h0012, 8'h03);
		read_expect(16'h0013, 8'h00);
		idle_for(8'd30);
		pin_expect(K_IRQ, 8'h01);
		// this read edge lands on the second expiry so the set wins over the clear
		read_expect(16'h0013, 8'h01);
		// irq enable off with the flag still pending
		write_at(16'h0012, 8'h01);
		pin_expect(K_IRQ, 8'h00);
		read_expect(16'h0013, 8'h01);
		// the previous status read cleared the flag
		read_expect(16'h0013, 8'h00);
		// register readback
		read_expect(16'h0010, 8'd20);
		read_expect(16'h0011, 8'h00);
		read_expect(16'h0012, 8'h01);
		// upper address byte ignored
		write_at(16'hab01, 8'h96);
		pin_expect(K_GPO0, 8'h96);
		pin_expect(K_GPO1, 8'h3c);
		read_expect(16'hab02, gpi_val[3]);
	endtask

	// ------------------------------
	// checking and bus driving
	// ------------------------------
	task automatic compare_byte(input string name, input io_pkg::bus_data_t exp,
		input io_pkg::bus_data_t got, input io_pkg::bus_data_t mask);
		if ((got & mask) != (exp & mask)) begin
			$display("ERR %s exp 0x%02h got 0x%02h", name, exp & mask, got & mask);
			error_count++;
		end
	endtask

	function automatic string kind_text(input kind_t kind);
		case (kind)
			K_WRITE: return "write";
			K_READ:  return "read";
			K_WAIT:  return "wait";
			K_GPI:   return "gpi";
			K_GPO0:  return "gpo0";
			K_GPO1:  return "gpo1";
			default: return "irq";
		endcase
	endfunction

	// strobe high three cycles and low three with outputs sampled on the falling edge
	task automatic bus_access(input entry_t ent);
		int ready_seen;
		ready_seen = 0;
		for (int i = 0; i < 6; i++) begin
			@(posedge clk);
			if (i == 0) begin
				bus_address    <= ent.addr;
				bus_write_data <= ent.wdata;
				if (ent.kind == K_READ) begin
					bus_io_read <= 1'b1;
				end else begin
					bus_io_write <= 1'b1;
				end
			end else if (i == 3) begin
				bus_io_read  <= 1'b0;
				bus_io_write <= 1'b0;
			end
			@(negedge clk);
			if (bus_read_ready) begin
				ready_seen++;
				if (ent.kind == K_READ) begin
					compare_byte("bus_read_data", ent.exp, bus_read_data, ent.mask);
				end
			end
		end
		if (ent.kind == K_READ && ready_seen != 1) begin
			$display("read of 0x%04h saw bus_read_ready %0d times, not once", ent.addr, ready_seen);
			error_count++;
		end
		if (ent.kind == K_WRITE && ready_seen != 0) begin
			$display("write to 0x%04h raised bus_read_ready", ent.addr);
			error_count++;
		end
	endtask

	task automatic apply_entry(input int idx, input entry_t ent);
		int errors_before;
		errors_before = error_count;
		case (ent.kind)
			K_WRITE, K_READ: bus_access(ent);
			K_WAIT: begin
				repeat (ent.wdata) begin
					@(posedge clk);
					@(negedge clk);
				end
			end
			K_GPI: begin
				@(posedge clk);
				if (ent.addr[0]) begin
					gpi1 <= ent.wdata;
				end else begin
					gpi0 <= ent.wdata;
				end
				@(negedge clk);
			end
			K_GPO0:  compare_byte("gpo0", ent.exp, gpo0, ent.mask);
			K_GPO1:  compare_byte("gpo1", ent.exp, gpo1, ent.mask);
			default: compare_byte("timer_irq", ent.exp, {7'd0, timer_irq}, ent.mask);
		endcase
		if (error_count == errors_before) begin
			pass_count++;
			$display("test %0d %s 0x%04h ok", idx, kind_text(ent.kind), ent.addr);
		end else begin
			fail_count++;
			$display("test %0d %s 0x%04h failed", idx, kind_text(ent.kind), ent.addr);
		end
	endtask

	// ------------------------------
	// watchdog and main sequence
	// ------------------------------
	initial begin
		wait (watchdog_cycles != 0);
		repeat (watchdog_cycles) @(posedge clk);
		$display("watchdog expired after %0d cycles, the table never finished", watchdog_cycles);
		$display("TEST FAIL");
		$finish;
	end

	initial begin
		int wait_total;
		// gpi values with the first pair at start and the second pair mid run
		seed = 32'h939e_e964;
		for (int i = 0; i < 4; i++) begin
			rnd        = $random(seed);
			gpi_val[i] = rnd[7:0];
		end
		n_reset        = 1'b0;
		bus_address    = '0;
		bus_write_data = '0;
		bus_io_read    = 1'b0;
		bus_io_write   = 1'b0;
		gpi0           = gpi_val[0];
		gpi1           = gpi_val[1];
		build_table();
		// ten cycles per entry plus idle waits and reset
		wait_total = 0;
		foreach (table_q[i]) begin
			if (table_q[i].kind == K_WAIT) begin
				wait_total += int'(table_q[i].wdata);
			end
		end
		watchdog_cycles = 16 + 10 * table_q.size() + wait_total;
		repeat (16) @(posedge clk);
		n_reset <= 1'b1;
		@(negedge clk);
		foreach (table_q[i]) begin
			apply_entry(i, table_q[i]);
		end
		$display("tests %0d, passed %0d, failed %0d, errors %0d",
			table_q.size(), pass_count, fail_count, error_count);
		if (fail_count == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule
